// File: include/cp15Defs.svh
`ifndef cp15DefsSvh
`define cp15DefsSvh

// **************************************************
// Reset values
// **************************************************

// ID register contents after reset, overridable per core
`define cp15DefaultMainId 32'h41069265

// Control word after reset
// L, D and P set, plus two fixed upper bits
`define cp15ControlReset 32'h00090070

// **************************************************
// Register indices
// **************************************************

// Control word
`define cp15RegControl 4'd1
// Translation table base
`define cp15RegTbase 4'd2
// Cache maintenance, write only in effect
`define cp15RegCache 4'd7
// TLB maintenance, write only in effect
`define cp15RegTlb 4'd8

`endif

// File: design/cp15Pkg.sv
`default_nettype none

`include "cp15Defs.svh"

package cp15Pkg;

  // **************************************************
  // Constants
  // **************************************************

  localparam logic [31:0] defaultMainId = `cp15DefaultMainId;
  localparam logic [31:0] controlReset  = `cp15ControlReset;

  localparam logic [3:0] regControl = `cp15RegControl;
  localparam logic [3:0] regTbase   = `cp15RegTbase;
  localparam logic [3:0] regCache   = `cp15RegCache;
  localparam logic [3:0] regTlb     = `cp15RegTlb;

  // Writable bits per register, index 0 first
  // Zero mask means the register never changes after reset
  localparam logic [31:0] writeMask [16] = '{
    32'h00000000, 32'h0000FFFF, 32'hFFFFC000, 32'hFFFFFFFF,
    32'h00000000, 32'h000001FF, 32'hFFFFFFFF, 32'h00000000,
    32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
    32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000
  };

  // **************************************************
  // Types
  // **************************************************

  // One requester, en alone reads, en with writeEn writes
  typedef struct packed {
    logic        en;
    logic        writeEn;
    logic [3:0]  addr;
    logic [31:0] writeData;
  } cp15Req_s;

  // Access after arbitration
  typedef struct packed {
    logic        write;
    logic        read;
    logic        fromCpu;
    logic [3:0]  addr;
    logic [31:0] data;
    logic [2:0]  opcode2;
    logic [3:0]  crm;
  } cp15Access_s;

  // Control word fields, MSB first
  // Bits 15:14 carry no named function here
  typedef struct packed {
    logic [15:0] sbz;
    logic [1:0]  resvHigh;
    logic        v;
    logic        i;
    logic [1:0]  resvLow;
    logic        r;
    logic        s;
    logic        b;
    logic        l;
    logic        d;
    logic        p;
    logic        w;
    logic        c;
    logic        a;
    logic        m;
  } controlFields_s;

  typedef union packed {
    logic [31:0]    raw;
    controlFields_s fields;
  } control_u;

  // Single cycle maintenance strobes
  typedef struct packed {
    logic invI;
    logic invD;
    logic cleanI;
    logic cleanD;
    logic tlbFlushI;
    logic tlbFlushD;
  } maintPulses_s;

endpackage

`default_nettype wire

// File: design/cp15PortArbiter.sv
`default_nettype none

module cp15PortArbiter (
  input  cp15Pkg::cp15Req_s    cpuReq,
  input  logic [2:0]           opcode2,
  input  logic [3:0]           crm,
  input  cp15Pkg::cp15Req_s    mmuReq,
  input  logic [31:0]          readData,
  output cp15Pkg::cp15Access_s access,
  output logic                 stallCp,
  output logic [31:0]          rd
);

  // **************************************************
  // Grant
  // **************************************************

  logic              mmuGrant;
  logic              cpuGrant;
  cp15Pkg::cp15Req_s granted;

  // MMU always wins
  assign mmuGrant = mmuReq.en;
  // CPU only when the MMU is idle
  assign cpuGrant = cpuReq.en & ~mmuReq.en;

  // Conflict rule
  // Any two accesses in the same cycle, two writes among them
  assign stallCp = cpuReq.en & mmuReq.en;

  // Pick the winning request
  assign granted = mmuGrant ? mmuReq : cpuReq;

  // **************************************************
  // Access forming
  // **************************************************

  always_comb begin
    access.write   = granted.en & granted.writeEn;
    access.read    = granted.en & ~granted.writeEn;
    access.fromCpu = cpuGrant;
    access.addr    = granted.addr;
    access.data    = granted.writeData;
    // Maintenance operands exist on the CPU side only
    access.opcode2 = opcode2;
    access.crm     = crm;
  end

  // **************************************************
  // Read return
  // **************************************************

  // Zero unless a read was actually granted this cycle
  assign rd = access.read ? readData : 32'h0;

endmodule

`default_nettype wire

// File: design/cp15RegFile.sv
`default_nettype none

module cp15RegFile #(
  parameter logic [31:0] mainId = cp15Pkg::defaultMainId
) (
  input  logic                 clk,
  input  logic                 reset,
  input  cp15Pkg::cp15Access_s access,
  output logic [31:0]          readData,
  output cp15Pkg::control_u    control,
  output logic [31:0]          tbase
);

  // **************************************************
  // Storage
  // **************************************************

  logic [31:0] regs [16];

  // Masked merge for the addressed register
  logic [31:0] curValue;
  logic [31:0] curMask;
  logic [31:0] mergedValue;

  assign curValue = regs[access.addr];
  assign curMask  = cp15Pkg::writeMask[access.addr];

  // Writable bits take new data, the rest hold
  assign mergedValue = (curValue & ~curMask) | (access.data & curMask);

  // **************************************************
  // Update
  // **************************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int idx = 0; idx < 16; idx++) begin
        if (idx == 0) begin
          // ID register
          regs[idx] <= mainId;
        end else if (idx == int'(cp15Pkg::regControl)) begin
          regs[idx] <= cp15Pkg::controlReset;
        end else begin
          regs[idx] <= 32'h0;
        end
      end
    end else if (access.write) begin
      // Read-only registers have a zero mask and keep their value
      regs[access.addr] <= mergedValue;
    end
  end

  // **************************************************
  // Read and fixed outputs
  // **************************************************

  // Unconditional read, the arbiter decides if it is returned
  assign readData = curValue;

  // Control word and table base go straight to the MMU side
  assign control.raw = regs[cp15Pkg::regControl];
  assign tbase       = regs[cp15Pkg::regTbase];

endmodule

`default_nettype wire

// File: design/cp15MaintDecode.sv
`default_nettype none

module cp15MaintDecode (
  input  cp15Pkg::cp15Access_s  access,
  output cp15Pkg::maintPulses_s maint
);

  // **************************************************
  // Qualify
  // **************************************************

  logic opValid;
  logic cacheOp;
  logic tlbOp;

  // Only CPU writes with opcode2 of 0 or 1 count
  assign opValid = access.fromCpu & access.write & (access.opcode2[2:1] == 2'b00);

  assign cacheOp = opValid & (access.addr == cp15Pkg::regCache);
  assign tlbOp   = opValid & (access.addr == cp15Pkg::regTlb);

  // **************************************************
  // Cache operations, register 7
  // **************************************************

  always_comb begin
    {maint.invI, maint.invD, maint.cleanI, maint.cleanD} = 4'b0000;
    if (cacheOp) begin
      case (access.crm)
        // Invalidate both
        4'd7:  {maint.invI, maint.invD, maint.cleanI, maint.cleanD} = 4'b1100;
        // Invalidate I only
        4'd5:  {maint.invI, maint.invD, maint.cleanI, maint.cleanD} = 4'b1000;
        // Invalidate D only
        4'd6:  {maint.invI, maint.invD, maint.cleanI, maint.cleanD} = 4'b0100;
        // Clean both
        4'd11: {maint.invI, maint.invD, maint.cleanI, maint.cleanD} = 4'b0011;
        // Clean D only
        4'd10: {maint.invI, maint.invD, maint.cleanI, maint.cleanD} = 4'b0001;
        // Clean and invalidate both
        4'd15: {maint.invI, maint.invD, maint.cleanI, maint.cleanD} = 4'b1111;
        // Clean and invalidate D
        4'd14: {maint.invI, maint.invD, maint.cleanI, maint.cleanD} = 4'b0101;
        default: {maint.invI, maint.invD, maint.cleanI, maint.cleanD} = 4'b0000;
      endcase
    end
  end

  // **************************************************
  // TLB operations, register 8
  // **************************************************

  always_comb begin
    {maint.tlbFlushI, maint.tlbFlushD} = 2'b00;
    if (tlbOp) begin
      case (access.crm)
        // Flush both TLBs
        4'd7:    {maint.tlbFlushI, maint.tlbFlushD} = 2'b11;
        // Instruction TLB
        4'd5:    {maint.tlbFlushI, maint.tlbFlushD} = 2'b10;
        // Data TLB
        4'd6:    {maint.tlbFlushI, maint.tlbFlushD} = 2'b01;
        default: {maint.tlbFlushI, maint.tlbFlushD} = 2'b00;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/coprocessor15.sv
`default_nettype none

module coprocessor15 #(
  parameter logic [31:0] mainId = cp15Pkg::defaultMainId
) (
  input  logic                  clk,
  input  logic                  reset,
  // CPU side, MCR writes and MRC reads
  input  cp15Pkg::cp15Req_s     cpuReq,
  input  logic [2:0]            opcode2,
  input  logic [3:0]            crm,
  // MMU side
  input  cp15Pkg::cp15Req_s     mmuReq,
  output logic                  stallCp,
  output logic [31:0]           rd,
  output cp15Pkg::control_u     control,
  output logic [31:0]           tbase,
  output cp15Pkg::maintPulses_s maint
);

  // **************************************************
  // Internal wires
  // **************************************************

  cp15Pkg::cp15Access_s access;
  logic [31:0]          readData;

  // Port arbitration, MMU first
  cp15PortArbiter arbiter (
    .cpuReq   (cpuReq),
    .opcode2  (opcode2),
    .crm      (crm),
    .mmuReq   (mmuReq),
    .readData (readData),
    .access   (access),
    .stallCp  (stallCp),
    .rd       (rd)
  );

  // Register storage
  cp15RegFile #(
    .mainId (mainId)
  ) regFile (
    .clk      (clk),
    .reset    (reset),
    .access   (access),
    .readData (readData),
    .control  (control),
    .tbase    (tbase)
  );

  // Cache and TLB strobes
  cp15MaintDecode maintDecode (
    .access (access),
    .maint  (maint)
  );

endmodule

`default_nettype wire

// File: sim/coprocessor15_asserts.sv
`default_nettype none

module coprocessor15_asserts (
  input logic                 clk,
  input logic                 reset,
  input cp15Pkg::cp15Req_s    cpuReq,
  input cp15Pkg::cp15Req_s    mmuReq,
  input cp15Pkg::cp15Access_s access,
  input logic                 stallCp,
  input logic [31:0]          rd
);

  // Conflict seen from the two request ports
  logic bothEnabled;
  logic readGranted;

  assign bothEnabled = cpuReq.en & mmuReq.en;
  // Winning side reads, MMU first
  assign readGranted = mmuReq.en ? ~mmuReq.writeEn : (cpuReq.en & ~cpuReq.writeEn);

  // Stall exactly on a conflict, and a stalled CPU is not served
  stallRule: assert property (@(posedge clk)
    bothEnabled ? (stallCp && !access.fromCpu) : !stallCp)
    else begin
      $error("stallCp differs from the conflict rule");
      coprocessor15Tb.assertFailures = coprocessor15Tb.assertFailures + 1;
    end

  // Nothing gets written while reset is held
  resetWriteRule: assert property (@(posedge clk) reset |-> !access.write)
    else begin
      $error("write granted during reset");
      coprocessor15Tb.assertFailures = coprocessor15Tb.assertFailures + 1;
    end

  // Read bus stays quiet without a granted read
  idleReadRule: assert property (@(posedge clk) !readGranted |-> rd == 32'h0)
    else begin
      $error("rd nonzero without a granted read");
      coprocessor15Tb.assertFailures = coprocessor15Tb.assertFailures + 1;
    end

endmodule

`default_nettype wire

// File: sim/coprocessor15Tb.sv
`default_nettype none

module coprocessor15Tb;

  localparam int period = 100;
  // Sample point inside the low clock phase
  localparam int settle = 25;
  localparam int resetCycles = 8;
  localparam int stallLimit = 8;
  localparam int plannedTransactions = 240;
  // Deliberately not the package default
  localparam logic [31:0] testId = 32'h4107A5C3;

  logic                  clk = 1'b0;
  logic                  reset;
  cp15Pkg::cp15Req_s     cpuReq;
  cp15Pkg::cp15Req_s     mmuReq;
  logic [2:0]            opcode2;
  logic [3:0]            crm;
  logic                  stallCp;
  logic [31:0]           rd;
  cp15Pkg::control_u     control;
  logic [31:0]           tbase;
  cp15Pkg::maintPulses_s maint;

  int          errors;
  int          checks;
  int          assertFailures;
  logic [31:0] rngState;
  // Expected register contents
  logic [31:0] model [16];

  coprocessor15 #(
    .mainId (testId)
  ) uut (
    .clk     (clk),
    .reset   (reset),
    .cpuReq  (cpuReq),
    .opcode2 (opcode2),
    .crm     (crm),
    .mmuReq  (mmuReq),
    .stallCp (stallCp),
    .rd      (rd),
    .control (control),
    .tbase   (tbase),
    .maint   (maint)
  );

  bind cp15PortArbiter coprocessor15_asserts asserts (
    .clk     (coprocessor15Tb.clk),
    .reset   (coprocessor15Tb.reset),
    .cpuReq  (cpuReq),
    .mmuReq  (mmuReq),
    .access  (access),
    .stallCp (stallCp),
    .rd      (rd)
  );

  always #(period / 2) clk = ~clk;

  // **************************************************
  // Helpers
  // **************************************************

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic drawRandom(output logic [31:0] value);
    rngState = xorshift32(rngState);
    value = rngState;
  endtask

  function automatic cp15Pkg::cp15Req_s makeReq(input logic en, input logic writeEn,
                                                input logic [3:0] addr, input logic [31:0] data);
    cp15Pkg::cp15Req_s req;
    req.en = en;
    req.writeEn = writeEn;
    req.addr = addr;
    req.writeData = data;
    return req;
  endfunction

  // Writable bits take the new value, others hold
  function automatic logic [31:0] mergeMasked(input logic [3:0] addr, input logic [31:0] oldValue,
                                              input logic [31:0] newValue);
    logic [31:0] mask;
    mask = cp15Pkg::writeMask[addr];
    return (oldValue & ~mask) | (newValue & mask);
  endfunction

  // Maintenance tables, cache bits invI invD cleanI cleanD
  function automatic cp15Pkg::maintPulses_s expectedPulses(input logic [3:0] addr,
                                                           input logic [2:0] op2,
                                                           input logic [3:0] cm);
    logic [3:0] cacheBits;
    logic [1:0] tlbBits;
    cacheBits = 4'b0000;
    tlbBits = 2'b00;
    if (op2 <= 3'd1 && addr == 4'd7) begin
      case (cm)
        4'd7:    cacheBits = 4'b1100;
        4'd5:    cacheBits = 4'b1000;
        4'd6:    cacheBits = 4'b0100;
        4'd11:   cacheBits = 4'b0011;
        4'd10:   cacheBits = 4'b0001;
        4'd15:   cacheBits = 4'b1111;
        4'd14:   cacheBits = 4'b0101;
        default: cacheBits = 4'b0000;
      endcase
    end else if (op2 <= 3'd1 && addr == 4'd8) begin
      case (cm)
        4'd7:    tlbBits = 2'b11;
        4'd5:    tlbBits = 2'b10;
        4'd6:    tlbBits = 2'b01;
        default: tlbBits = 2'b00;
      endcase
    end
    return {cacheBits, tlbBits};
  endfunction

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic driveInputs(input cp15Pkg::cp15Req_s cpu, input cp15Pkg::cp15Req_s mmu,
                             input logic [2:0] op2, input logic [3:0] cm);
    @(negedge clk);
    cpuReq = cpu;
    mmuReq = mmu;
    opcode2 = op2;
    crm = cm;
    #(settle);
  endtask

  task automatic releaseInputs;
    @(negedge clk);
    cpuReq = '0;
    mmuReq = '0;
    opcode2 = 3'd0;
    crm = 4'd0;
  endtask

  // CPU repeats its request while stalled
  task automatic cpuAccess(input cp15Pkg::cp15Req_s req, input logic [2:0] op2,
                           input logic [3:0] cm, output logic [31:0] data,
                           output cp15Pkg::maintPulses_s pulses, output int stallCycles);
    stallCycles = 0;
    driveInputs(req, '0, op2, cm);
    while (stallCp === 1'b1 && stallCycles < stallLimit) begin
      @(negedge clk);
      #(settle);
      stallCycles++;
    end
    if (stallCp !== 1'b0) begin
      errors++;
      $display("CPU request to register %0d was never granted", req.addr);
    end
    data = rd;
    pulses = maint;
    releaseInputs();
  endtask

  task automatic cpuWrite(input logic [3:0] addr, input logic [31:0] value,
                          input logic [2:0] op2, input logic [3:0] cm);
    logic [31:0] data;
    cp15Pkg::maintPulses_s pulses;
    int stallCycles;
    cpuAccess(makeReq(1'b1, 1'b1, addr, value), op2, cm, data, pulses, stallCycles);
    checkValue("stallCp cycles", 32'(stallCycles), 32'd0);
    checkValue("rd", data, 32'h0);
    checkValue("maint", 32'(pulses), 32'(expectedPulses(addr, op2, cm)));
    model[addr] = mergeMasked(addr, model[addr], value);
  endtask

  task automatic checkRegister(input logic [3:0] addr);
    logic [31:0] data;
    cp15Pkg::maintPulses_s pulses;
    int stallCycles;
    cpuAccess(makeReq(1'b1, 1'b0, addr, 32'h0), 3'd0, 4'd0, data, pulses, stallCycles);
    checkValue("stallCp cycles", 32'(stallCycles), 32'd0);
    checkValue("maint", 32'(pulses), 32'h0);
    checkValue($sformatf("register %0d", addr), data, model[addr]);
  endtask

  // MMU side never waits, CPU pins left at a live cache code
  task automatic mmuAccess(input cp15Pkg::cp15Req_s req, output logic [31:0] data);
    driveInputs('0, req, 3'd0, 4'd7);
    checkValue("stallCp", 32'(stallCp), 32'd0);
    checkValue("maint", 32'(maint), 32'h0);
    data = rd;
    releaseInputs();
  endtask

  task automatic mmuWrite(input logic [3:0] addr, input logic [31:0] value);
    logic [31:0] data;
    mmuAccess(makeReq(1'b1, 1'b1, addr, value), data);
    checkValue("rd", data, 32'h0);
    model[addr] = mergeMasked(addr, model[addr], value);
  endtask

  task automatic mmuRead(input logic [3:0] addr);
    logic [31:0] data;
    mmuAccess(makeReq(1'b1, 1'b0, addr, 32'h0), data);
    checkValue($sformatf("MMU read of register %0d", addr), data, model[addr]);
  endtask

  task automatic checkOutputs;
    checkValue("control", control.raw, model[1]);
    checkValue("tbase", tbase, model[2]);
  endtask

  task automatic checkIdle;
    checkValue("stallCp", 32'(stallCp), 32'd0);
    checkValue("rd", rd, 32'h0);
    checkValue("maint", 32'(maint), 32'h0);
  endtask

  // **************************************************
  // Tests
  // **************************************************

  task automatic resetTest;
    for (int idx = 0; idx < 16; idx++) begin
      checkRegister(4'(idx));
    end
    checkOutputs();
    checkIdle();
  endtask

  // Two rounds so the merge sees nonzero old values
  task automatic randomWriteTest;
    logic [31:0] value;
    logic [31:0] extra;
    for (int round = 0; round < 2; round++) begin
      for (int idx = 0; idx < 16; idx++) begin
        drawRandom(value);
        drawRandom(extra);
        cpuWrite(4'(idx), value, {1'b0, extra[1:0]}, extra[7:4]);
      end
      for (int idx = 0; idx < 16; idx++) begin
        checkRegister(4'(idx));
      end
      checkOutputs();
    end
  endtask

  task automatic mmuTest;
    logic [31:0] value;
    drawRandom(value);
    mmuWrite(4'd6, value);
    checkRegister(4'd6);
    mmuRead(4'd6);
    drawRandom(value);
    cpuWrite(4'd5, value, 3'd0, 4'd0);
    mmuRead(4'd5);
    drawRandom(value);
    mmuWrite(4'd5, value);
    mmuRead(4'd5);
    // M and C on, A off, upper half is not writable
    cpuWrite(4'd1, 32'hFFFF0005, 3'd0, 4'd0);
    checkValue("control.m", 32'(control.fields.m), 32'd1);
    checkValue("control.c", 32'(control.fields.c), 32'd1);
    checkValue("control.a", 32'(control.fields.a), 32'd0);
    // M and C off, I on
    mmuWrite(4'd1, 32'h00001078);
    checkValue("control.m", 32'(control.fields.m), 32'd0);
    checkValue("control.c", 32'(control.fields.c), 32'd0);
    checkValue("control.i", 32'(control.fields.i), 32'd1);
    drawRandom(value);
    cpuWrite(4'd2, value, 3'd0, 4'd0);
    checkOutputs();
  endtask

  task automatic conflictTest;
    logic [31:0] cpuValue;
    logic [31:0] mmuValue;
    drawRandom(cpuValue);
    drawRandom(mmuValue);
    // Both write register 3, MMU is served
    driveInputs(makeReq(1'b1, 1'b1, 4'd3, cpuValue), makeReq(1'b1, 1'b1, 4'd3, mmuValue),
                3'd0, 4'd0);
    checkValue("stallCp", 32'(stallCp), 32'd1);
    model[3] = mergeMasked(4'd3, model[3], mmuValue);
    // CPU holds, MMU reads back its own value
    driveInputs(makeReq(1'b1, 1'b1, 4'd3, cpuValue), makeReq(1'b1, 1'b0, 4'd3, 32'h0),
                3'd0, 4'd0);
    checkValue("stallCp", 32'(stallCp), 32'd1);
    checkValue("rd", rd, model[3]);
    // MMU gone, held CPU write lands
    driveInputs(makeReq(1'b1, 1'b1, 4'd3, cpuValue), '0, 3'd0, 4'd0);
    checkValue("stallCp", 32'(stallCp), 32'd0);
    model[3] = mergeMasked(4'd3, model[3], cpuValue);
    releaseInputs();
    checkRegister(4'd3);
    // Both read, rd shows the MMU register
    driveInputs(makeReq(1'b1, 1'b0, 4'd2, 32'h0), makeReq(1'b1, 1'b0, 4'd3, 32'h0),
                3'd0, 4'd0);
    checkValue("stallCp", 32'(stallCp), 32'd1);
    checkValue("rd", rd, model[3]);
    driveInputs(makeReq(1'b1, 1'b0, 4'd2, 32'h0), '0, 3'd0, 4'd0);
    checkValue("stallCp", 32'(stallCp), 32'd0);
    checkValue("rd", rd, model[2]);
    releaseInputs();
  endtask

  // Full sweep of CRm and opcode2 on both maintenance registers
  task automatic maintTest;
    logic [31:0] value;
    logic [3:0]  target;
    for (int sel = 0; sel < 2; sel++) begin
      target = (sel == 0) ? 4'd7 : 4'd8;
      for (int op2 = 0; op2 < 4; op2++) begin
        for (int cm = 0; cm < 16; cm++) begin
          drawRandom(value);
          cpuWrite(target, value, 3'(op2), 4'(cm));
        end
      end
    end
    drawRandom(value);
    mmuWrite(4'd7, value);
    checkRegister(4'd7);
  endtask

  // **************************************************
  // Main sequence and watchdog
  // **************************************************

  initial begin
    reset = 1'b1;
    cpuReq = '0;
    mmuReq = '0;
    opcode2 = 3'd0;
    crm = 4'd0;
    rngState = 32'h8cb236ef;
    errors = 0;
    checks = 0;
    for (int idx = 0; idx < 16; idx++) begin
      model[idx] = 32'h0;
    end
    model[0] = testId;
    model[1] = cp15Pkg::controlReset;
    repeat (resetCycles) @(posedge clk);
    #(settle);
    checkIdle();
    @(negedge clk);
    reset = 1'b0;
    resetTest();
    randomWriteTest();
    mmuTest();
    conflictTest();
    maintTest();
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, assertFailures);
    if (errors == 0 && assertFailures == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Four cycles of budget per planned transaction
  initial begin
    #(plannedTransactions * period * 4);
    $display("Timeout, the tests did not finish within %0d time units",
             plannedTransactions * period * 4);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: cp15.f
+incdir+include
design/cp15Pkg.sv
design/cp15PortArbiter.sv
design/cp15RegFile.sv
design/cp15MaintDecode.sv
design/coprocessor15.sv
sim/coprocessor15_asserts.sv
sim/coprocessor15Tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the CP15 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module coprocessor15Tb -f cp15.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# A high error limit lets the testbench count assertion failures itself
simOutput=$(./obj_dir/Vcoprocessor15Tb +verilator+error+limit+1000)
simStatus=$?
echo "$simOutput"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if echo "$simOutput" | grep -qx "Everything OK"; then
  echo "Result: pass"
  exit 0
fi
echo "Result: fail"
exit 1
